/* common/id_ctrl_pkg.sv */
//////////////////////////////
// Control types used inside the decode stage and on its ports.
// ALU operators, operand selects and the packed structs between blocks.
//////////////////////////////

`default_nettype none

package id_ctrl_pkg;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA,
    OR, AND, EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  typedef enum logic {
    WB_EX,
    WB_LSU
  } wb_sel_e;

  // Writeback sequencer states
  typedef enum logic {
    SEQ_IDLE,
    SEQ_WAIT
  } seq_state_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // From fetch, is_new marks the first cycle of an instruction
  typedef struct packed {
    logic                          valid;
    logic                          is_new;
    logic [id_isa_pkg::xlen-1:0]   instr;
    logic [id_isa_pkg::xlen-1:0]   pc;
  } if_id_t;

  typedef struct packed {
    logic [id_isa_pkg::reg_addr_w-1:0] raddr_a;
    logic [id_isa_pkg::reg_addr_w-1:0] raddr_b;
    logic [id_isa_pkg::reg_addr_w-1:0] waddr;
    logic                              we;
    wb_sel_e                           wb_sel;
    alu_op_e                           alu_op;
    op_a_sel_e                         op_a_sel;
    op_b_sel_e                         op_b_sel;
    id_isa_pkg::imm_sel_e              imm_sel;
    logic                              lsu_req;
    logic                              lsu_we;
    logic [1:0]                        lsu_size;
    logic                              lsu_sign_ext;
    logic                              branch;
    logic                              jump;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e                     alu_op;
    logic [id_isa_pkg::xlen-1:0] operand_a;
    logic [id_isa_pkg::xlen-1:0] operand_b;
  } ex_req_t;

  typedef struct packed {
    logic                        req;
    logic                        we;
    logic [1:0]                  size;
    logic                        sign_ext;
    logic [id_isa_pkg::xlen-1:0] wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

/* common/id_isa_pkg.sv */
//////////////////////////////
// RV32I encoding constants for the decode stage. Opcodes, instruction field
// positions and immediate formats, shared by the decoder and immediate logic.
//////////////////////////////

`default_nettype none

package id_isa_pkg;

  // Data path and register index widths
  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned num_regs   = 32;

  // Instruction field start positions
  localparam int unsigned rd_lsb     = 7;
  localparam int unsigned funct3_lsb = 12;
  localparam int unsigned rs1_lsb    = 15;
  localparam int unsigned rs2_lsb    = 20;
  localparam int unsigned funct7_lsb = 25;

  // Return address offset for JAL
  localparam logic [xlen-1:0] pc_incr = 32'd4;

  //////////////////////////////
  // Major opcodes
  //////////////////////////////

  typedef enum logic [6:0] {
    OPC_LOAD   = 7'h03,
    OPC_OP_IMM = 7'h13,
    OPC_AUIPC  = 7'h17,
    OPC_STORE  = 7'h23,
    OPC_OP     = 7'h33,
    OPC_LUI    = 7'h37,
    OPC_BRANCH = 7'h63,
    OPC_JAL    = 7'h6f
  } opcode_e;

  //////////////////////////////
  // Immediate formats
  //////////////////////////////

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J,
    IMM_INCR_PC
  } imm_sel_e;

endpackage

`default_nettype wire

/* decoder/id_decoder.sv */
//////////////////////////////
// Instruction decoder. Turns one RV32I word into the control struct
// and flags unknown opcodes and reserved funct fields.
//////////////////////////////

`default_nettype none

module id_decoder (
  input  logic [id_isa_pkg::xlen-1:0] instr_i,
  output id_ctrl_pkg::dec_ctrl_t      ctrl_o,
  output logic                        illegal_o
);

  import id_isa_pkg::*;
  import id_ctrl_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  opcode_e    opcode;

  // Shared by OP and OP-IMM, alt picks SUB or SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? SUB : ADD;
      3'b001:  op = SLL;
      3'b010:  op = SLT;
      3'b011:  op = SLTU;
      3'b100:  op = XOR;
      3'b101:  op = alt ? SRA : SRL;
      3'b110:  op = OR;
      default: op = AND;
    endcase
    return op;
  endfunction

  assign funct3 = instr_i[funct3_lsb +: 3];
  assign funct7 = instr_i[funct7_lsb +: 7];
  assign opcode = opcode_e'(instr_i[6:0]);

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.raddr_a  = instr_i[rs1_lsb +: reg_addr_w];
    ctrl_o.raddr_b  = instr_i[rs2_lsb +: reg_addr_w];
    ctrl_o.waddr    = instr_i[rd_lsb +: reg_addr_w];
    ctrl_o.wb_sel   = WB_EX;
    ctrl_o.alu_op   = ADD;
    ctrl_o.op_a_sel = OP_A_REG;
    ctrl_o.op_b_sel = OP_B_IMM;
    ctrl_o.imm_sel  = IMM_I;
    illegal_o       = 1'b0;

    case (opcode)
      OPC_OP: begin
        ctrl_o.we       = 1'b1;
        ctrl_o.op_b_sel = OP_B_REG;
        ctrl_o.alu_op   = arith_op(funct3, funct7[5]);
        // Alternate funct7 only exists for SUB and SRA
        case (funct7)
          7'h00:   illegal_o = 1'b0;
          7'h20:   illegal_o = (funct3 != 3'b000) && (funct3 != 3'b101);
          default: illegal_o = 1'b1;
        endcase
      end

      OPC_OP_IMM: begin
        ctrl_o.we     = 1'b1;
        ctrl_o.alu_op = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);
        if (funct3 == 3'b001) begin
          illegal_o = (funct7 != 7'h00);
        end else if (funct3 == 3'b101) begin
          illegal_o = (funct7 != 7'h00) && (funct7 != 7'h20);
        end
      end

      OPC_LUI: begin
        ctrl_o.we       = 1'b1;
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.imm_sel  = IMM_U;
      end

      OPC_AUIPC: begin
        ctrl_o.we       = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.imm_sel  = IMM_U;
      end

      OPC_LOAD: begin
        ctrl_o.we           = 1'b1;
        ctrl_o.wb_sel       = WB_LSU;
        ctrl_o.lsu_req      = 1'b1;
        ctrl_o.lsu_size     = funct3[1:0];
        ctrl_o.lsu_sign_ext = ~funct3[2];
        // LB LH LW LBU LHU only
        illegal_o = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
      end

      OPC_STORE: begin
        ctrl_o.lsu_req  = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.lsu_size = funct3[1:0];
        ctrl_o.imm_sel  = IMM_S;
        illegal_o       = funct3[2] || (funct3[1:0] == 2'b11);
      end

      OPC_BRANCH: begin
        ctrl_o.branch   = 1'b1;
        ctrl_o.op_b_sel = OP_B_REG;
        ctrl_o.imm_sel  = IMM_B;
        case (funct3)
          3'b000:  ctrl_o.alu_op = EQ;
          3'b001:  ctrl_o.alu_op = NE;
          3'b100:  ctrl_o.alu_op = LT;
          3'b101:  ctrl_o.alu_op = GE;
          3'b110:  ctrl_o.alu_op = LTU;
          3'b111:  ctrl_o.alu_op = GEU;
          default: illegal_o     = 1'b1;
        endcase
      end

      OPC_JAL: begin
        // ALU computes PC + 4 as the link value
        ctrl_o.we       = 1'b1;
        ctrl_o.jump     = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.imm_sel  = IMM_INCR_PC;
      end

      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* decoder/id_imm_extract.sv */
//////////////////////////////
// Immediate extraction. Builds the sign-extended RV32I immediates
// and returns the one chosen by the decoder.
//////////////////////////////

`default_nettype none

module id_imm_extract (
  input  logic [id_isa_pkg::xlen-1:0] instr_i,
  input  id_isa_pkg::imm_sel_e        imm_sel_i,
  output logic [id_isa_pkg::xlen-1:0] imm_o
);

  import id_isa_pkg::*;

  logic [xlen-1:0] imm_i_type;
  logic [xlen-1:0] imm_s_type;
  logic [xlen-1:0] imm_b_type;
  logic [xlen-1:0] imm_u_type;
  logic [xlen-1:0] imm_j_type;

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // Branch and jump offsets are in halfwords
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21],
                       1'b0};

  always_comb begin
    case (imm_sel_i)
      IMM_I:       imm_o = imm_i_type;
      IMM_S:       imm_o = imm_s_type;
      IMM_B:       imm_o = imm_b_type;
      IMM_U:       imm_o = imm_u_type;
      IMM_J:       imm_o = imm_j_type;
      IMM_INCR_PC: imm_o = pc_incr;
      default:     imm_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* id_stage.f */
common/id_isa_pkg.sv
common/id_ctrl_pkg.sv
decoder/id_decoder.sv
decoder/id_imm_extract.sv
verilog/id_register_file.sv
verilog/id_operand_mux.sv
verilog/id_wb_sequencer.sv
verilog/id_stage.sv
testbench/id_stage_checker.sv
testbench/id_stage_tb.sv

/* testbench/id_stage_checker.sv */
//////////////////////////////
// Protocol assertions on the writeback sequencer.
// Bound into id_wb_sequencer by the bind at the end of this file.
//////////////////////////////

`default_nettype none

module id_stage_checker (
  input logic                    clk_i,
  input logic                    rst_ni,
  input id_ctrl_pkg::lsu_req_t   lsu_req_i,
  input logic                    id_ready_i,
  input id_ctrl_pkg::seq_state_e state_i,
  input logic                    illegal_i,
  input logic                    rf_we_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import id_ctrl_pkg::*;

  // Number of failed assertions
  int unsigned fail_count = 0;

  // LSU request is a one-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   lsu_req_i.req |=> !lsu_req_i.req)
    else begin
      fail_count++;
      $error("LSU request high in two consecutive cycles");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (state_i == SEQ_WAIT) |-> !id_ready_i)
    else begin
      fail_count++;
      $error("id_ready_o high while the sequencer waits");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   illegal_i |-> !rf_we_i)
    else begin
      fail_count++;
      $error("Register file written by an illegal instruction");
    end

endmodule

bind id_wb_sequencer id_stage_checker checker_i (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .lsu_req_i  (lsu_req_o),
  .id_ready_i (id_ready_o),
  .state_i    (state_q),
  .illegal_i  (illegal_i),
  .rf_we_i    (rf_we_o)
);

`default_nettype wire

/* testbench/id_stage_tb.sv */
//////////////////////////////
// Testbench for the decode stage. Random RV32I instructions, with the
// testbench acting as fetch, EX and LSU, checked against a register model.
//////////////////////////////

`default_nettype none

module id_stage_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import id_isa_pkg::*;
  import id_ctrl_pkg::*;

  localparam int clk_period     = 40;
  localparam int reset_cycles   = 8;
  localparam int per_test       = 40;
  localparam int num_rand_tests = 6;
  localparam int num_instr      = per_test * num_rand_tests + 2 * num_regs;
  // Worst case is new, three wait cycles, completion and one bubble
  localparam int timeout_cycles = num_instr * 6 + reset_cycles;

  logic            clk;
  logic            rst_n;
  if_id_t          if_id;
  logic            branch_decision;
  logic            ex_valid;
  logic            lsu_valid;
  logic [xlen-1:0] wdata_ex;
  logic [xlen-1:0] wdata_lsu;
  ex_req_t         ex_req;
  lsu_req_t        lsu_req;
  logic            id_ready;
  logic            instr_ret;
  logic            illegal_insn;

  logic [31:0]     seed;
  logic [xlen-1:0] ref_regs [num_regs];
  logic [xlen-1:0] next_pc;
  int              error_count;
  int              check_count;
  int              cycle_count;

  id_stage dut_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .if_id_i           (if_id),
    .branch_decision_i (branch_decision),
    .ex_valid_i        (ex_valid),
    .lsu_valid_i       (lsu_valid),
    .wdata_ex_i        (wdata_ex),
    .wdata_lsu_i       (wdata_lsu),
    .ex_req_o          (ex_req),
    .lsu_req_o         (lsu_req),
    .id_ready_o        (id_ready),
    .instr_ret_o       (instr_ret),
    .illegal_insn_o    (illegal_insn)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int unsigned rand_range(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return r[31:8] % n;
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // RV32I legality of the kept opcodes
  function automatic logic ref_legal(input logic [31:0] instr);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ok;
    f3 = instr[14:12];
    f7 = instr[31:25];
    case (instr[6:0])
      OPC_OP:     ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
      OPC_OP_IMM: ok = (f3 == 3'd1) ? (f7 == 7'h00) :
                       (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      OPC_LUI, OPC_AUIPC, OPC_JAL: ok = 1'b1;
      OPC_LOAD:   ok = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
      OPC_STORE:  ok = (f3 <= 3'd2);
      OPC_BRANCH: ok = (f3 != 3'd2) && (f3 != 3'd3);
      default:    ok = 1'b0;
    endcase
    return ok;
  endfunction

  function automatic alu_op_e ref_alu_op(input logic [31:0] instr);
    alu_op_e op;
    op = ADD;
    if (instr[6:0] == OPC_OP || instr[6:0] == OPC_OP_IMM) begin
      case (instr[14:12])
        3'd0:    op = (instr[6:0] == OPC_OP && instr[30]) ? SUB : ADD;
        3'd1:    op = SLL;
        3'd2:    op = SLT;
        3'd3:    op = SLTU;
        3'd4:    op = XOR;
        3'd5:    op = instr[30] ? SRA : SRL;
        3'd6:    op = OR;
        default: op = AND;
      endcase
    end else if (instr[6:0] == OPC_BRANCH) begin
      case (instr[14:12])
        3'd0:    op = EQ;
        3'd1:    op = NE;
        3'd4:    op = LT;
        3'd5:    op = GE;
        3'd6:    op = LTU;
        default: op = GEU;
      endcase
    end
    return op;
  endfunction

  // Category 0 ALU, 1 upper and jump, 2 memory, 3 branch, other illegal
  function automatic logic [31:0] make_instr(input int unsigned category);
    logic [31:0] word;
    int unsigned pick;
    word = next_rand();
    pick = rand_range(4);
    case (category)
      0: begin
        word[6:0] = pick[0] ? OPC_OP : OPC_OP_IMM;
        // Mostly valid funct7, sometimes random
        if (rand_range(4) != 0) begin
          word[31:25] = word[30] ? 7'h20 : 7'h00;
        end
      end
      1: begin
        case (rand_range(3))
          0:       word[6:0] = OPC_LUI;
          1:       word[6:0] = OPC_AUIPC;
          default: word[6:0] = OPC_JAL;
        endcase
      end
      2: word[6:0] = pick[0] ? OPC_LOAD : OPC_STORE;
      3: word[6:0] = OPC_BRANCH;
      default: begin
        case (pick)
          0: word[6:0] = 7'h73;
          1: word[6:0] = 7'h67;
          2: word[1:0] = 2'b00;
          default: begin
            // MUL/DIV space
            word[6:0]   = OPC_OP;
            word[31:25] = 7'h01;
          end
        endcase
      end
    endcase
    return word;
  endfunction

  //////////////////////////////
  // Instruction driver and checks
  //////////////////////////////

  task automatic issue_instr(input logic [31:0] instr);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [4:0]      rd;
    logic            legal;
    logic            taken;
    logic            is_mem;
    logic            waits;
    logic [xlen-1:0] exp_a;
    logic [xlen-1:0] exp_b;
    int unsigned     wait_cycles;

    opc    = instr[6:0];
    f3     = instr[14:12];
    rd     = instr[11:7];
    legal  = ref_legal(instr);
    is_mem = (opc == OPC_LOAD) || (opc == OPC_STORE);
    case (opc)
      OPC_LUI:            exp_a = '0;
      OPC_AUIPC, OPC_JAL: exp_a = next_pc;
      default:            exp_a = ref_regs[instr[19:15]];
    endcase
    case (opc)
      OPC_OP, OPC_BRANCH: exp_b = ref_regs[instr[24:20]];
      OPC_STORE:          exp_b = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      OPC_LUI, OPC_AUIPC: exp_b = {instr[31:12], 12'h000};
      OPC_JAL:            exp_b = 32'd4;
      default:            exp_b = {{20{instr[31]}}, instr[31:20]};
    endcase

    @(posedge clk);
    #2;
    taken           = rand_range(2);
    if_id.valid     = 1'b1;
    if_id.is_new    = 1'b1;
    if_id.instr     = instr;
    if_id.pc        = next_pc;
    branch_decision = taken;
    ex_valid        = 1'b0;
    lsu_valid       = 1'b0;
    wdata_ex        = next_rand();
    wdata_lsu       = next_rand();
    waits = legal && (is_mem || opc == OPC_JAL || (opc == OPC_BRANCH && taken));
    #(clk_period / 2 - 2);

    compare_value("illegal_insn_o", illegal_insn, !legal);
    compare_value("lsu_req_o.req", lsu_req.req, legal && is_mem);
    compare_value("instr_ret_o", instr_ret, legal && !waits);
    if (legal) begin
      compare_value("ex_req_o.alu_op", ex_req.alu_op, ref_alu_op(instr));
      compare_value("ex_req_o.operand_a", ex_req.operand_a, exp_a);
      compare_value("ex_req_o.operand_b", ex_req.operand_b, exp_b);
    end
    if (legal && is_mem) begin
      compare_value("lsu_req_o.we", lsu_req.we, opc == OPC_STORE);
      compare_value("lsu_req_o.size", lsu_req.size, f3[1:0]);
      compare_value("lsu_req_o.sign_ext", lsu_req.sign_ext, opc == OPC_LOAD && !f3[2]);
    end
    if (legal && opc == OPC_STORE) begin
      compare_value("lsu_req_o.wdata", lsu_req.wdata, ref_regs[instr[24:20]]);
    end
    if (!waits) begin
      compare_value("id_ready_o", id_ready, 1'b1);
    end
    if (legal && !waits && opc != OPC_STORE && opc != OPC_BRANCH && rd != 0) begin
      ref_regs[rd] = wdata_ex;
    end

    if (waits) begin
      wait_cycles = rand_range(4);
      repeat (wait_cycles) begin
        @(posedge clk);
        #2;
        if_id.is_new = 1'b0;
        wdata_ex     = next_rand();
        wdata_lsu    = next_rand();
        #(clk_period / 2 - 2);
        compare_value("id_ready_o while waiting", id_ready, 1'b0);
        compare_value("lsu_req_o.req while waiting", lsu_req.req, 1'b0);
        compare_value("instr_ret_o while waiting", instr_ret, 1'b0);
      end
      // Completion cycle
      @(posedge clk);
      #2;
      if_id.is_new = 1'b0;
      lsu_valid    = is_mem;
      ex_valid     = !is_mem;
      wdata_ex     = next_rand();
      wdata_lsu    = next_rand();
      #(clk_period / 2 - 2);
      compare_value("instr_ret_o on completion", instr_ret, 1'b1);
      compare_value("id_ready_o on completion", id_ready, 1'b0);
      compare_value("lsu_req_o.req on completion", lsu_req.req, 1'b0);
      if (opc == OPC_LOAD && rd != 0) begin
        ref_regs[rd] = wdata_lsu;
      end else if (opc == OPC_JAL && rd != 0) begin
        ref_regs[rd] = wdata_ex;
      end
      // Bubble before the next instruction
      @(posedge clk);
      #2;
      if_id.valid  = 1'b0;
      if_id.is_new = 1'b0;
      ex_valid     = 1'b0;
      lsu_valid    = 1'b0;
      #(clk_period / 2 - 2);
      compare_value("id_ready_o after completion", id_ready, 1'b1);
      compare_value("instr_ret_o after completion", instr_ret, 1'b0);
    end
    next_pc = next_pc + 32'd4;
  endtask

  // ADDI x0, xN, 0 shows register N on operand A
  task automatic read_back_regs();
    for (int i = 0; i < num_regs; i++) begin
      issue_instr({12'h000, 5'(i), 3'b000, 5'b00000, 7'(OPC_OP_IMM)});
    end
  endtask

  task automatic run_random_test(input string name, input int unsigned category);
    int errors_before;
    int unsigned cat;
    errors_before = error_count;
    for (int n = 0; n < per_test; n++) begin
      cat = (category == 5) ? rand_range(5) : category;
      issue_instr(make_instr(cat));
    end
    $display("Test %s finished with %0d errors", name, error_count - errors_before);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int errors_before;
    seed            = 32'h97ca;
    error_count     = 0;
    check_count     = 0;
    next_pc         = 32'h0000_1000;
    rst_n           = 1'b0;
    if_id           = '0;
    branch_decision = 1'b0;
    ex_valid        = 1'b0;
    lsu_valid       = 1'b0;
    wdata_ex        = '0;
    wdata_lsu       = '0;
    for (int i = 0; i < num_regs; i++) begin
      ref_regs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;

    errors_before = error_count;
    #(clk_period / 2 - 2);
    compare_value("id_ready_o after reset", id_ready, 1'b1);
    compare_value("lsu_req_o.req after reset", lsu_req.req, 1'b0);
    compare_value("instr_ret_o after reset", instr_ret, 1'b0);
    read_back_regs();
    $display("Test reset_state finished with %0d errors", error_count - errors_before);

    run_random_test("alu", 0);
    run_random_test("upper_jal", 1);
    run_random_test("load_store", 2);
    run_random_test("branch", 3);
    run_random_test("illegal", 4);
    run_random_test("mixed", 5);

    errors_before = error_count;
    read_back_regs();
    $display("Test register_readback finished with %0d errors",
             error_count - errors_before);

    error_count = error_count + dut_i.wb_sequencer_i.checker_i.fail_count;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/id_operand_mux.sv */
//////////////////////////////
// ALU operand selection. Picks operand A and B for the EX request
// and passes register B on as store data.
//////////////////////////////

`default_nettype none

module id_operand_mux (
  input  id_ctrl_pkg::dec_ctrl_t      ctrl_i,
  input  logic [id_isa_pkg::xlen-1:0] pc_i,
  input  logic [id_isa_pkg::xlen-1:0] rdata_a_i,
  input  logic [id_isa_pkg::xlen-1:0] rdata_b_i,
  input  logic [id_isa_pkg::xlen-1:0] imm_i,
  output id_ctrl_pkg::ex_req_t        ex_req_o,
  output logic [id_isa_pkg::xlen-1:0] store_data_o
);

  import id_ctrl_pkg::*;

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   ex_req_o.operand_a = pc_i;
      OP_A_ZERO: ex_req_o.operand_a = '0;
      default:   ex_req_o.operand_a = rdata_a_i;
    endcase
  end

  assign ex_req_o.operand_b = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_i : rdata_b_i;
  assign ex_req_o.alu_op    = ctrl_i.alu_op;

  assign store_data_o = rdata_b_i;

endmodule

`default_nettype wire

/* verilog/id_register_file.sv */
//////////////////////////////
// Integer register file with two read ports and one write port.
// x0 reads zero, writes land on the next clock edge.
//////////////////////////////

`default_nettype none

module id_register_file (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [id_isa_pkg::reg_addr_w-1:0] raddr_a_i,
  input  logic [id_isa_pkg::reg_addr_w-1:0] raddr_b_i,
  output logic [id_isa_pkg::xlen-1:0]       rdata_a_o,
  output logic [id_isa_pkg::xlen-1:0]       rdata_b_o,
  input  logic [id_isa_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [id_isa_pkg::xlen-1:0]       wdata_i,
  input  logic                              we_i
);

  import id_isa_pkg::*;

  // Registers 1 to 31, x0 has no storage
  logic [xlen-1:0] regs_q [1:num_regs-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* verilog/id_stage.sv */
//////////////////////////////
// RV32I instruction decode stage top. Connects decoder, immediates,
// register file, operand mux and writeback sequencer.
//////////////////////////////

`default_nettype none

module id_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  id_ctrl_pkg::if_id_t         if_id_i,
  input  logic                        branch_decision_i,
  input  logic                        ex_valid_i,
  input  logic                        lsu_valid_i,
  input  logic [id_isa_pkg::xlen-1:0] wdata_ex_i,
  input  logic [id_isa_pkg::xlen-1:0] wdata_lsu_i,
  output id_ctrl_pkg::ex_req_t        ex_req_o,
  output id_ctrl_pkg::lsu_req_t       lsu_req_o,
  output logic                        id_ready_o,
  output logic                        instr_ret_o,
  output logic                        illegal_insn_o
);

  import id_isa_pkg::*;
  import id_ctrl_pkg::*;

  dec_ctrl_t       ctrl;
  logic            illegal_dec;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] rdata_a;
  logic [xlen-1:0] rdata_b;
  logic [xlen-1:0] store_data;
  logic [xlen-1:0] rf_wdata;
  logic            rf_we;

  assign illegal_insn_o = if_id_i.valid & illegal_dec;

  //////////////////////////////
  // Decode
  //////////////////////////////

  id_decoder decoder_i (
    .instr_i   (if_id_i.instr),
    .ctrl_o    (ctrl),
    .illegal_o (illegal_dec)
  );

  id_imm_extract imm_extract_i (
    .instr_i   (if_id_i.instr),
    .imm_sel_i (ctrl.imm_sel),
    .imm_o     (imm)
  );

  //////////////////////////////
  // Registers and operands
  //////////////////////////////

  id_register_file register_file_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (ctrl.raddr_a),
    .raddr_b_i (ctrl.raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (ctrl.waddr),
    .wdata_i   (rf_wdata),
    .we_i      (rf_we)
  );

  id_operand_mux operand_mux_i (
    .ctrl_i       (ctrl),
    .pc_i         (if_id_i.pc),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .imm_i        (imm),
    .ex_req_o     (ex_req_o),
    .store_data_o (store_data)
  );

  //////////////////////////////
  // Writeback
  //////////////////////////////

  id_wb_sequencer wb_sequencer_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .if_id_i           (if_id_i),
    .ctrl_i            (ctrl),
    .illegal_i         (illegal_dec),
    .store_data_i      (store_data),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .lsu_valid_i       (lsu_valid_i),
    .wdata_ex_i        (wdata_ex_i),
    .wdata_lsu_i       (wdata_lsu_i),
    .lsu_req_o         (lsu_req_o),
    .rf_we_o           (rf_we),
    .rf_wdata_o        (rf_wdata),
    .id_ready_o        (id_ready_o),
    .instr_ret_o       (instr_ret_o)
  );

endmodule

`default_nettype wire

/* verilog/id_wb_sequencer.sv */
//////////////////////////////
// Writeback sequencer. Holds loads, stores, jumps and taken branches
// until LSU or EX completes, gates requests and register writes,
// and drives ready and retire.
//////////////////////////////

`default_nettype none

module id_wb_sequencer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  id_ctrl_pkg::if_id_t         if_id_i,
  input  id_ctrl_pkg::dec_ctrl_t      ctrl_i,
  input  logic                        illegal_i,
  input  logic [id_isa_pkg::xlen-1:0] store_data_i,
  input  logic                        branch_decision_i,
  input  logic                        ex_valid_i,
  input  logic                        lsu_valid_i,
  input  logic [id_isa_pkg::xlen-1:0] wdata_ex_i,
  input  logic [id_isa_pkg::xlen-1:0] wdata_lsu_i,
  output id_ctrl_pkg::lsu_req_t       lsu_req_o,
  output logic                        rf_we_o,
  output logic [id_isa_pkg::xlen-1:0] rf_wdata_o,
  output logic                        id_ready_o,
  output logic                        instr_ret_o
);

  import id_ctrl_pkg::*;

  seq_state_e state_q;
  seq_state_e state_n;
  logic       done_q;
  logic       done_n;
  logic       multicycle;
  logic       needs_wait;
  logic       executing;
  logic       legal_exec;
  logic       start;
  logic       we_fsm;
  logic       ret_fsm;
  logic       stall;

  assign multicycle = ctrl_i.lsu_req | ctrl_i.branch | ctrl_i.jump;
  assign needs_wait = ctrl_i.lsu_req | ctrl_i.jump | (ctrl_i.branch & branch_decision_i);

  // New instruction, or multicycle one that has not finished yet
  assign executing  = if_id_i.valid & (if_id_i.is_new | (multicycle & ~done_q));
  assign legal_exec = executing & ~illegal_i;
  assign start      = legal_exec & if_id_i.is_new & (state_q == SEQ_IDLE);

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      done_q  <= done_n;
    end
  end

  always_comb begin
    state_n = state_q;
    done_n  = done_q;
    we_fsm  = 1'b0;
    ret_fsm = 1'b0;
    stall   = 1'b0;

    case (state_q)
      SEQ_IDLE: begin
        if (if_id_i.valid && if_id_i.is_new) begin
          // Illegal ones are marked done at once
          done_n = 1'b1;
          if (!illegal_i && needs_wait) begin
            state_n = SEQ_WAIT;
            done_n  = 1'b0;
            stall   = 1'b1;
          end else if (!illegal_i) begin
            we_fsm  = ctrl_i.we;
            ret_fsm = 1'b1;
          end
        end
      end

      SEQ_WAIT: begin
        stall = 1'b1;
        if (ctrl_i.lsu_req ? lsu_valid_i : ex_valid_i) begin
          state_n = SEQ_IDLE;
          done_n  = 1'b1;
          we_fsm  = ctrl_i.we;
          ret_fsm = 1'b1;
        end
      end

      default: begin
        state_n = SEQ_IDLE;
      end
    endcase
  end

  // LSU request lives only in the first cycle
  assign lsu_req_o.req      = start & ctrl_i.lsu_req;
  assign lsu_req_o.we       = ctrl_i.lsu_we;
  assign lsu_req_o.size     = ctrl_i.lsu_size;
  assign lsu_req_o.sign_ext = ctrl_i.lsu_sign_ext;
  assign lsu_req_o.wdata    = store_data_i;

  assign rf_we_o     = legal_exec & we_fsm;
  assign rf_wdata_o  = (ctrl_i.wb_sel == WB_LSU) ? wdata_lsu_i : wdata_ex_i;
  assign instr_ret_o = legal_exec & ret_fsm;
  assign id_ready_o  = ~stall;

endmodule

`default_nettype wire
